// ==== rtl/ofl_cfg.svh ====
`ifndef OFL_CFG_SVH
`define OFL_CFG_SVH

// ------------------------------------------------------------------------
// Channel count and data path widths
// ------------------------------------------------------------------------
`define OFL_N_CHAN   8
`define OFL_W_CHAN   3
`define OFL_W_DELTA  18
`define OFL_W_MULT   8
`define OFL_W_RS     5
`define OFL_W_DOUT   32

// Configuration write bus
`define OFL_W_ADDR   4
`define OFL_W_WDATA  32

// ------------------------------------------------------------------------
// Write bus address map
// ------------------------------------------------------------------------
`define OFL_ADDR_MIN       4'd0
`define OFL_ADDR_MAX       4'd1
`define OFL_ADDR_INIT      4'd2
`define OFL_ADDR_MULT      4'd3
`define OFL_ADDR_RS        4'd4
`define OFL_ADDR_ADD_CHAN  4'd5
// Request registers act on data bit 0
`define OFL_ADDR_INJ       4'd6
`define OFL_ADDR_CLR       4'd7

`endif

// ==== rtl/ofl_pkg.sv ====
`include "ofl_cfg.svh"

package ofl_pkg;

    // Channel index
    typedef logic [`OFL_W_CHAN-1:0] chan_t;

    // Add channel is one bit wider, so N_CHAN and above select no partner
    typedef logic [`OFL_W_CHAN:0] add_chan_t;

    // Reset value of every add channel entry
    localparam add_chan_t ADD_CHAN_NONE = add_chan_t'(`OFL_N_CHAN);

    // Input sample and per-channel gain
    typedef logic signed [`OFL_W_DELTA-1:0] delta_t;
    typedef logic signed [`OFL_W_MULT-1:0] mult_t;

    // Arithmetic right shift amount
    typedef logic [`OFL_W_RS-1:0] rs_t;

    // Full product width, the shift never needs more
    typedef logic signed [`OFL_W_DELTA+`OFL_W_MULT-1:0] scaled_t;

    // Filter output, bounds and initial value
    typedef logic signed [`OFL_W_DOUT-1:0] dout_t;

    // Write bus fields
    typedef logic [`OFL_W_ADDR-1:0] wr_addr_t;
    typedef logic [`OFL_W_WDATA-1:0] wr_data_t;

endpackage

// ==== rtl/ofl_wr_if.sv ====
`timescale 1ns/100ps

// Configuration write bus
// A write lands on the rising edge where en is high, with no acknowledge
interface ofl_wr_if import ofl_pkg::*; ();

    logic     en;
    wr_addr_t addr;
    chan_t    chan;
    wr_data_t data;

    // Driven from the top-level write ports
    modport source (output en, output addr, output chan, output data);

    // Register block side
    modport sink (input en, input addr, input chan, input data);

endinterface

// ==== rtl/ofl_cfg_regs.sv ====
`timescale 1ns/100ps

`include "ofl_cfg.svh"

module ofl_cfg_regs import ofl_pkg::*; (
    input  logic                   clk_in,
    input  logic                   reset,
    ofl_wr_if.sink                 wr,
    input  logic                   dv_in,
    input  logic                   inj_taken,
    output dout_t                  min_cfg [0:`OFL_N_CHAN-1],
    output dout_t                  max_cfg [0:`OFL_N_CHAN-1],
    output dout_t                  init_cfg [0:`OFL_N_CHAN-1],
    output mult_t                  mult_cfg [0:`OFL_N_CHAN-1],
    output rs_t                    rs_cfg [0:`OFL_N_CHAN-1],
    output add_chan_t              add_chan_cfg [0:`OFL_N_CHAN-1],
    output logic [`OFL_N_CHAN-1:0] clr_mask,
    output logic                   inj_req,
    output chan_t                  inj_chan
);

    // Pending inject requests, one per channel
    logic [`OFL_N_CHAN-1:0] inj_pend;
    logic [`OFL_N_CHAN-1:0] inj_next;
    // Requests still eligible this cycle
    logic [`OFL_N_CHAN-1:0] inj_live;

    // ------------------------------------------------------------------------
    // Configuration arrays
    // ------------------------------------------------------------------------

    // Bounds, init, gain and shift hold no reset
    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            case (wr.addr)
                `OFL_ADDR_MIN:  min_cfg[wr.chan]  <= wr.data[`OFL_W_DOUT-1:0];
                `OFL_ADDR_MAX:  max_cfg[wr.chan]  <= wr.data[`OFL_W_DOUT-1:0];
                `OFL_ADDR_INIT: init_cfg[wr.chan] <= wr.data[`OFL_W_DOUT-1:0];
                `OFL_ADDR_MULT: mult_cfg[wr.chan] <= wr.data[`OFL_W_MULT-1:0];
                `OFL_ADDR_RS:   rs_cfg[wr.chan]   <= wr.data[`OFL_W_RS-1:0];
                default: begin
                end
            endcase
        end
    end

    // Partner selection starts out as none for every channel
    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < `OFL_N_CHAN; i++) begin
                add_chan_cfg[i] <= ADD_CHAN_NONE;
            end
        end else if (wr.en && wr.addr == `OFL_ADDR_ADD_CHAN) begin
            add_chan_cfg[wr.chan] <= wr.data[`OFL_W_CHAN:0];
        end
    end

    // ------------------------------------------------------------------------
    // Request registers
    // ------------------------------------------------------------------------

    // Write sets or drops a request, the granted one falls, clear wins last
    always_comb begin
        inj_next = inj_pend;
        if (wr.en && wr.addr == `OFL_ADDR_INJ) begin
            inj_next[wr.chan] = wr.data[0];
        end
        if (inj_taken) begin
            inj_next[inj_chan] = 1'b0;
        end
        inj_next = inj_next & ~clr_mask;
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            inj_pend <= '0;
            clr_mask <= '0;
        end else begin
            inj_pend <= inj_next;
            // Clear pulses are one cycle long unless written again
            clr_mask <= '0;
            if (wr.en && wr.addr == `OFL_ADDR_CLR) begin
                clr_mask[wr.chan] <= wr.data[0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // Inject arbiter
    // ------------------------------------------------------------------------

    // A channel under clear is not offered
    assign inj_live = inj_pend & ~clr_mask;

    // Downward scan so the lowest pending channel is chosen last
    always_comb begin
        inj_chan = '0;
        for (int i = `OFL_N_CHAN - 1; i >= 0; i--) begin
            if (inj_live[i]) begin
                inj_chan = chan_t'(i);
            end
        end
    end

    // Injection only uses idle input slots
    assign inj_req = (|inj_live) && !dv_in;

endmodule

// ==== rtl/ofl_pipe.sv ====
`timescale 1ns/100ps

`include "ofl_cfg.svh"

module ofl_pipe import ofl_pkg::*; (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   dv_in,
    input  chan_t                  chan_in,
    input  delta_t                 delta_in,
    input  dout_t                  min_cfg [0:`OFL_N_CHAN-1],
    input  dout_t                  max_cfg [0:`OFL_N_CHAN-1],
    input  dout_t                  init_cfg [0:`OFL_N_CHAN-1],
    input  mult_t                  mult_cfg [0:`OFL_N_CHAN-1],
    input  rs_t                    rs_cfg [0:`OFL_N_CHAN-1],
    input  add_chan_t              add_chan_cfg [0:`OFL_N_CHAN-1],
    input  logic [`OFL_N_CHAN-1:0] clr_mask,
    input  logic                   inj_req,
    input  chan_t                  inj_chan,
    output logic                   inj_taken,
    output logic                   dv_out,
    output chan_t                  chan_out,
    output dout_t                  data_out
);

    // Scaled delta plus partner, then one more bit for the previous output
    localparam int W_SUM = $bits(scaled_t) + 1;
    localparam int W_UC  = ((W_SUM > `OFL_W_DOUT) ? W_SUM : `OFL_W_DOUT) + 1;

    typedef logic signed [W_SUM-1:0] sum_t;
    typedef logic signed [W_UC-1:0]  uc_t;

    // Per-channel state
    dout_t   prev_mem [0:`OFL_N_CHAN-1];
    scaled_t scaled_mem [0:`OFL_N_CHAN-1];

    // Channels flushed this cycle, all of them on reset
    logic [`OFL_N_CHAN-1:0] flush_chan;

    // Input selection
    logic   sel_inj;
    chan_t  sel_chan;
    delta_t sel_delta;

    // Stage registers
    logic      valid_p1, valid_p2, valid_p3, valid_p4, valid_p5;
    logic      inj_p1, inj_p2, inj_p3, inj_p4;
    chan_t     chan_p1, chan_p2, chan_p3, chan_p4, chan_p5;
    delta_t    delta_p1;
    mult_t     mult_p1;
    rs_t       rs_p1;
    add_chan_t add_chan_p1;
    scaled_t   scaled_p2, add_scaled_p2;
    sum_t      sum_p3;
    dout_t     prev_p3, max_p3, min_p3;
    dout_t     clamp_p4, init_p4;
    dout_t     result_p5;

    // Combinational arithmetic
    scaled_t product;
    uc_t     uc_sum;
    dout_t   result;

    assign flush_chan = clr_mask | {`OFL_N_CHAN{reset}};

    // ------------------------------------------------------------------------
    // Stage 1 fetch
    // ------------------------------------------------------------------------

    // Idle input slot goes to a pending injection with zero delta
    assign sel_inj   = inj_req && !dv_in;
    assign sel_chan  = dv_in ? chan_in : inj_chan;
    assign sel_delta = dv_in ? delta_in : '0;
    assign inj_taken = sel_inj;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_p1 <= 1'b0;
        end else begin
            valid_p1 <= (dv_in || sel_inj) && !clr_mask[sel_chan];
        end
        inj_p1      <= sel_inj;
        chan_p1     <= sel_chan;
        delta_p1    <= sel_delta;
        mult_p1     <= mult_cfg[sel_chan];
        rs_p1       <= rs_cfg[sel_chan];
        add_chan_p1 <= add_chan_cfg[sel_chan];
    end

    // ------------------------------------------------------------------------
    // Stage 2 scale
    // ------------------------------------------------------------------------

    // Sized by the assignment so the full product is kept
    assign product = delta_p1 * mult_p1;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_p2 <= 1'b0;
        end else begin
            valid_p2 <= valid_p1 && !clr_mask[chan_p1];
        end
        inj_p2    <= inj_p1;
        chan_p2   <= chan_p1;
        scaled_p2 <= product >>> rs_p1;
        // Partner's last stored scaled delta, zero when there is none
        if (add_chan_p1 < `OFL_N_CHAN) begin
            add_scaled_p2 <= scaled_mem[add_chan_p1[`OFL_W_CHAN-1:0]];
        end else begin
            add_scaled_p2 <= '0;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 3 add partner, store scaled delta
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_p3 <= 1'b0;
        end else begin
            valid_p3 <= valid_p2 && !clr_mask[chan_p2];
        end
        inj_p3  <= inj_p2;
        chan_p3 <= chan_p2;
        sum_p3  <= scaled_p2 + add_scaled_p2;
        prev_p3 <= prev_mem[chan_p2];
        max_p3  <= max_cfg[chan_p2];
        min_p3  <= min_cfg[chan_p2];
    end

    // Zeroing on reset or clear overrides a store to the same entry
    always_ff @(posedge clk_in) begin
        if (valid_p2) begin
            scaled_mem[chan_p2] <= scaled_p2;
        end
        for (int i = 0; i < `OFL_N_CHAN; i++) begin
            if (flush_chan[i]) begin
                scaled_mem[i] <= '0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stage 4 accumulate and clamp
    // ------------------------------------------------------------------------
    assign uc_sum = sum_p3 + prev_p3;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_p4 <= 1'b0;
        end else begin
            valid_p4 <= valid_p3 && !clr_mask[chan_p3];
        end
        inj_p4  <= inj_p3;
        chan_p4 <= chan_p3;
        init_p4 <= init_cfg[chan_p3];
        // Saturate at the channel bounds
        if (uc_sum > max_p3) begin
            clamp_p4 <= max_p3;
        end else if (uc_sum < min_p3) begin
            clamp_p4 <= min_p3;
        end else begin
            clamp_p4 <= uc_sum[`OFL_W_DOUT-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // Stage 5 select and writeback
    // ------------------------------------------------------------------------

    // Injection forces the initial value
    assign result = inj_p4 ? init_p4 : clamp_p4;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            valid_p5 <= 1'b0;
        end else begin
            valid_p5 <= valid_p4 && !clr_mask[chan_p4];
        end
        chan_p5   <= chan_p4;
        result_p5 <= result;
    end

    // Reload from init on reset or clear, taking priority over writeback
    always_ff @(posedge clk_in) begin
        if (valid_p4) begin
            prev_mem[chan_p4] <= result;
        end
        for (int i = 0; i < `OFL_N_CHAN; i++) begin
            if (flush_chan[i]) begin
                prev_mem[i] <= init_cfg[i];
            end
        end
    end

    // Output registers, five edges after the input was taken
    always_ff @(posedge clk_in) begin
        if (reset) begin
            dv_out <= 1'b0;
        end else begin
            dv_out <= valid_p5 && !clr_mask[chan_p5];
        end
        chan_out <= chan_p5;
        data_out <= result_p5;
    end

endmodule

// ==== rtl/ofl_top.sv ====
`timescale 1ns/100ps

`include "ofl_cfg.svh"

module ofl_top import ofl_pkg::*; (
    input  logic     clk_in,
    input  logic     reset,
    input  logic     dv_in,
    input  chan_t    chan_in,
    input  delta_t   delta_in,
    input  logic     wr_en,
    input  wr_addr_t wr_addr,
    input  chan_t    wr_chan,
    input  wr_data_t wr_data,
    output logic     dv_out,
    output chan_t    chan_out,
    output dout_t    data_out
);

    // Configuration from the register block to the pipeline
    dout_t                  min_cfg [0:`OFL_N_CHAN-1];
    dout_t                  max_cfg [0:`OFL_N_CHAN-1];
    dout_t                  init_cfg [0:`OFL_N_CHAN-1];
    mult_t                  mult_cfg [0:`OFL_N_CHAN-1];
    rs_t                    rs_cfg [0:`OFL_N_CHAN-1];
    add_chan_t              add_chan_cfg [0:`OFL_N_CHAN-1];
    logic [`OFL_N_CHAN-1:0] clr_mask;

    // Inject handshake between the two blocks
    logic  inj_req;
    chan_t inj_chan;
    logic  inj_taken;

    // Write bus built from the plain top-level ports
    ofl_wr_if wr_bus ();

    assign wr_bus.en   = wr_en;
    assign wr_bus.addr = wr_addr;
    assign wr_bus.chan = wr_chan;
    assign wr_bus.data = wr_data;

    ofl_cfg_regs u_cfg_regs (
        .clk_in       (clk_in),
        .reset        (reset),
        .wr           (wr_bus.sink),
        .dv_in        (dv_in),
        .inj_taken    (inj_taken),
        .min_cfg      (min_cfg),
        .max_cfg      (max_cfg),
        .init_cfg     (init_cfg),
        .mult_cfg     (mult_cfg),
        .rs_cfg       (rs_cfg),
        .add_chan_cfg (add_chan_cfg),
        .clr_mask     (clr_mask),
        .inj_req      (inj_req),
        .inj_chan     (inj_chan)
    );

    ofl_pipe u_pipe (
        .clk_in       (clk_in),
        .reset        (reset),
        .dv_in        (dv_in),
        .chan_in      (chan_in),
        .delta_in     (delta_in),
        .min_cfg      (min_cfg),
        .max_cfg      (max_cfg),
        .init_cfg     (init_cfg),
        .mult_cfg     (mult_cfg),
        .rs_cfg       (rs_cfg),
        .add_chan_cfg (add_chan_cfg),
        .clr_mask     (clr_mask),
        .inj_req      (inj_req),
        .inj_chan     (inj_chan),
        .inj_taken    (inj_taken),
        .dv_out       (dv_out),
        .chan_out     (chan_out),
        .data_out     (data_out)
    );

endmodule

// ==== dv/ofl_clk_gen.sv ====
`timescale 1ns/100ps

// Free-running clock and power-on reset for the testbench
module ofl_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2) clk_in = ~clk_in;
    end

    // Released on a rising edge so the DUT sees whole reset cycles
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        reset <= 1'b0;
    end

endmodule

// ==== dv/ofl_sva.sv ====
`timescale 1ns/100ps

`include "ofl_cfg.svh"

module ofl_sva import ofl_pkg::*; (
    input logic  clk_in,
    input logic  reset,
    input logic  dv_out,
    input chan_t chan_out,
    input dout_t data_out,
    input logic  inj_taken,
    input dout_t min_cfg [0:`OFL_N_CHAN-1],
    input dout_t max_cfg [0:`OFL_N_CHAN-1]
);

    // No output on any reset cycle or the one after it
    a_quiet_reset: assert property (@(posedge clk_in) reset |=> (!dv_out) [*2])
        else $error("dv_out high during or right after reset");

    // Sampled outputs belong to the item taken six edges earlier
    // Injections carry init, which may lie outside the bounds
    a_in_bounds: assert property (@(posedge clk_in) disable iff (reset)
        (dv_out && !$past(inj_taken, 6))
            |-> (data_out >= min_cfg[chan_out] && data_out <= max_cfg[chan_out]))
        else $error("data_out outside the bounds of its channel");

    a_chan_range: assert property (@(posedge clk_in) disable iff (reset)
        dv_out |-> (!$isunknown(chan_out) && chan_out < `OFL_N_CHAN))
        else $error("chan_out unknown or out of range");

endmodule

bind ofl_top ofl_sva u_ofl_sva (
    .clk_in    (clk_in),
    .reset     (reset),
    .dv_out    (dv_out),
    .chan_out  (chan_out),
    .data_out  (data_out),
    .inj_taken (inj_taken),
    .min_cfg   (min_cfg),
    .max_cfg   (max_cfg)
);

// ==== dv/ofl_tb.sv ====
`timescale 1ns/100ps

`include "ofl_cfg.svh"

module ofl_tb import ofl_pkg::*; ();

    // Sample counts per test
    localparam int N_T1 = 48;
    localparam int N_T2 = 40;
    localparam int N_T3 = 32;
    localparam int N_T6 = 32;
    // Worst case six ticks per sample, plus writes and drains
    localparam int MAX_TICKS   = 6 * (N_T1 + N_T2 + N_T3 + N_T6 + 18) + 240;
    localparam int WATCHDOG_NS = (MAX_TICKS + 50) * 40;
    // Output shows up six ticks after the tick that drives the input
    localparam int LAT = 6;

    logic     clk_in, por, rst_mid, reset;
    logic     dv_in, wr_en, dv_out;
    chan_t    chan_in, wr_chan, chan_out;
    delta_t   delta_in;
    wr_addr_t wr_addr;
    wr_data_t wr_data;
    dout_t    data_out;

    // Next tick's inputs, staged by the test tasks
    logic     s_dv, s_we, s_rst;
    chan_t    s_chan, s_wchan;
    delta_t   s_delta;
    wr_addr_t s_addr;
    wr_data_t s_wdata;

    // Reference model state
    longint m_min [0:`OFL_N_CHAN-1];
    longint m_max [0:`OFL_N_CHAN-1];
    longint m_init [0:`OFL_N_CHAN-1];
    longint m_prev [0:`OFL_N_CHAN-1];
    longint m_scaled [0:`OFL_N_CHAN-1];
    int     m_mult [0:`OFL_N_CHAN-1];
    int     m_rs [0:`OFL_N_CHAN-1];
    int     m_add [0:`OFL_N_CHAN-1];
    int     last_sent [0:`OFL_N_CHAN-1];
    logic [`OFL_N_CHAN-1:0] m_pend;

    // Expected outputs, a ring indexed by due tick
    bit    exp_valid [0:7];
    chan_t exp_chan [0:7];
    dout_t exp_data [0:7];

    logic [31:0] lfsr;
    int cyc;
    int err_mismatch, err_missing, err_unexpected;

    assign reset = por | rst_mid;

    ofl_clk_gen u_clk_gen (
        .clk_in (clk_in),
        .reset  (por)
    );

    ofl_top u_ofl_top (
        .clk_in   (clk_in),
        .reset    (reset),
        .dv_in    (dv_in),
        .chan_in  (chan_in),
        .delta_in (delta_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_chan  (wr_chan),
        .wr_data  (wr_data),
        .dv_out   (dv_out),
        .chan_out (chan_out),
        .data_out (data_out)
    );

    // ------------------------------------------------------------------------
    // Random bits, one LFSR step per bit
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // Taps 32 22 2 1
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_chan(input chan_t got, input chan_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: chan_out %0d, expected %0d", $time, got, exp);
            err_mismatch++;
        end
    endtask

    task automatic check_data(input dout_t got, input dout_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: data_out %0d, expected %0d", $time, got, exp);
            err_mismatch++;
        end
    endtask

    task automatic check_slot();
        int idx;
        idx = cyc % 8;
        if (exp_valid[idx]) begin
            if (dv_out !== 1'b1) begin
                $display("Missing output at %0t: no dv_out for channel %0d",
                         $time, exp_chan[idx]);
                err_missing++;
            end else begin
                check_chan(chan_out, exp_chan[idx]);
                check_data(data_out, exp_data[idx]);
            end
            exp_valid[idx] = 1'b0;
        end else if (dv_out !== 1'b0) begin
            $display("Unexpected output at %0t: dv_out high with no item due", $time);
            err_unexpected++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic expect_out(input chan_t ch, input longint val);
        int idx;
        idx = (cyc + LAT) % 8;
        exp_valid[idx] = 1'b1;
        exp_chan[idx]  = ch;
        exp_data[idx]  = dout_t'(val);
        last_sent[ch]  = cyc;
    endtask

    // Scale, add partner, accumulate, clamp
    task automatic model_sample(input chan_t ch, input delta_t d);
        longint sc;
        longint acc;
        sc  = (longint'(d) * m_mult[ch]) >>> m_rs[ch];
        acc = m_prev[ch] + sc;
        if (m_add[ch] < `OFL_N_CHAN) begin
            acc = acc + m_scaled[m_add[ch]];
        end
        if (acc > m_max[ch]) begin
            acc = m_max[ch];
        end else if (acc < m_min[ch]) begin
            acc = m_min[ch];
        end
        m_scaled[ch] = sc;
        m_prev[ch]   = acc;
        expect_out(ch, acc);
    endtask

    // Lowest pending channel wins, zero delta clears its stored scale
    task automatic model_inject();
        int c;
        c = 0;
        for (int i = `OFL_N_CHAN - 1; i >= 0; i--) begin
            if (m_pend[i]) c = i;
        end
        m_pend[c]   = 1'b0;
        m_prev[c]   = m_init[c];
        m_scaled[c] = 0;
        expect_out(chan_t'(c), m_init[c]);
    endtask

    task automatic model_reset();
        for (int s = 1; s <= LAT; s++) begin
            exp_valid[(cyc + s) % 8] = 1'b0;
        end
        for (int c = 0; c < `OFL_N_CHAN; c++) begin
            m_prev[c]   = m_init[c];
            m_scaled[c] = 0;
            m_add[c]    = `OFL_N_CHAN;
        end
        m_pend = '0;
    endtask

    task automatic model_write(input wr_addr_t a, input chan_t ch, input wr_data_t d);
        int idx;
        case (a)
            `OFL_ADDR_MIN:      m_min[ch] = longint'(dout_t'(d));
            `OFL_ADDR_MAX:      m_max[ch] = longint'(dout_t'(d));
            `OFL_ADDR_INIT:     m_init[ch] = longint'(dout_t'(d));
            `OFL_ADDR_MULT:     m_mult[ch] = int'(mult_t'(d[`OFL_W_MULT-1:0]));
            `OFL_ADDR_RS:       m_rs[ch] = int'(d[`OFL_W_RS-1:0]);
            `OFL_ADDR_ADD_CHAN: m_add[ch] = int'(d[`OFL_W_CHAN:0]);
            `OFL_ADDR_INJ:      m_pend[ch] = d[0];
            `OFL_ADDR_CLR: begin
                // Kills items of the channel taken up to the flush edge
                if (d[0]) begin
                    for (int s = 2; s <= LAT + 1; s++) begin
                        idx = (cyc + s) % 8;
                        if (exp_valid[idx] && exp_chan[idx] == ch) begin
                            exp_valid[idx] = 1'b0;
                        end
                    end
                    m_prev[ch]    = m_init[ch];
                    m_scaled[ch]  = 0;
                    m_pend[ch]    = 1'b0;
                    last_sent[ch] = cyc + 1;
                end
            end
            default: begin
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // One clock: drive staged inputs, update the model, check outputs
    task automatic tick();
        @(posedge clk_in);
        cyc++;
        dv_in    <= s_dv;
        chan_in  <= s_chan;
        delta_in <= s_delta;
        wr_en    <= s_we;
        wr_addr  <= s_addr;
        wr_chan  <= s_wchan;
        wr_data  <= s_wdata;
        rst_mid  <= s_rst;
        if (s_rst) begin
            model_reset();
        end else if (s_dv) begin
            model_sample(s_chan, s_delta);
        end else if (m_pend != '0) begin
            model_inject();
        end
        if (s_we && !s_rst) begin
            model_write(s_addr, s_wchan, s_wdata);
        end
        s_dv  = 1'b0;
        s_we  = 1'b0;
        s_rst = 1'b0;
        @(negedge clk_in);
        check_slot();
    endtask

    // Same-channel and partner spacing of five ticks
    function automatic bit chan_free(input chan_t ch);
        int p;
        p = m_add[ch];
        if (cyc + 1 - last_sent[ch] < 5) return 1'b0;
        if (p < `OFL_N_CHAN && cyc + 1 - last_sent[p] < 5) return 1'b0;
        return 1'b1;
    endfunction

    task automatic stage_write(input wr_addr_t a, input chan_t ch, input wr_data_t d);
        s_we    = 1'b1;
        s_addr  = a;
        s_wchan = ch;
        s_wdata = d;
    endtask

    task automatic write_cfg(input wr_addr_t a, input chan_t ch, input wr_data_t d);
        stage_write(a, ch, d);
        tick();
    endtask

    task automatic send_sample(input chan_t ch, input delta_t d);
        while (!chan_free(ch)) begin
            tick();
        end
        s_dv    = 1'b1;
        s_chan  = ch;
        s_delta = d;
        tick();
    endtask

    task automatic config_chan(input chan_t ch, input longint lo, input longint hi,
                               input longint ini, input int mu, input int sh);
        write_cfg(`OFL_ADDR_MIN, ch, wr_data_t'(lo));
        write_cfg(`OFL_ADDR_MAX, ch, wr_data_t'(hi));
        write_cfg(`OFL_ADDR_INIT, ch, wr_data_t'(ini));
        write_cfg(`OFL_ADDR_MULT, ch, wr_data_t'(mu));
        write_cfg(`OFL_ADDR_RS, ch, wr_data_t'(sh));
    endtask

    task automatic drain();
        repeat (LAT + 1) tick();
    endtask

    task automatic reset_pulse();
        repeat (4) begin
            s_rst = 1'b1;
            tick();
        end
        tick();
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        dv_in    = 1'b0;
        chan_in  = '0;
        delta_in = '0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_chan  = '0;
        wr_data  = '0;
        rst_mid  = 1'b0;
        s_dv     = 1'b0;
        s_we     = 1'b0;
        s_rst    = 1'b0;
        s_chan   = '0;
        s_wchan  = '0;
        s_delta  = '0;
        s_addr   = '0;
        s_wdata  = '0;
        lfsr     = 32'h4929;
        cyc      = 0;
        m_pend   = '0;
        err_mismatch   = 0;
        err_missing    = 0;
        err_unexpected = 0;
        for (int c = 0; c < `OFL_N_CHAN; c++) begin
            m_add[c]     = `OFL_N_CHAN;
            m_scaled[c]  = 0;
            m_prev[c]    = 0;
            last_sent[c] = -100;
        end
        for (int i = 0; i < 8; i++) exp_valid[i] = 1'b0;
        wait (!por);

        // Test 1 scaling and accumulation, wide bounds
        for (int c = 0; c < `OFL_N_CHAN; c++) begin
            config_chan(chan_t'(c), -(64'sd1 <<< 30), 64'sd1 <<< 30,
                        longint'($signed(16'(rand_bits(16)))),
                        int'(rand_bits(8)), int'(rand_bits(4)));
        end
        // Clear loads prev from init
        for (int c = 0; c < `OFL_N_CHAN; c++) begin
            write_cfg(`OFL_ADDR_CLR, chan_t'(c), 32'd1);
        end
        for (int i = 0; i < N_T1; i++) begin
            send_sample(chan_t'(rand_bits(3)), delta_t'(rand_bits(18)));
        end
        drain();

        // Test 2 clamping, narrow bounds and large deltas
        for (int c = 0; c < `OFL_N_CHAN; c++) begin
            config_chan(chan_t'(c), -(1000 + longint'(rand_bits(8))),
                        1000 + longint'(rand_bits(8)),
                        longint'($signed(8'(rand_bits(8)))),
                        int'(rand_bits(8)), int'(rand_bits(2)));
        end
        for (int i = 0; i < N_T2; i++) begin
            send_sample(chan_t'(rand_bits(3)), delta_t'(rand_bits(18)));
        end
        drain();

        // Test 3 cross-channel add, partners start from zero
        for (int c = 0; c < 4; c++) begin
            write_cfg(`OFL_ADDR_CLR, chan_t'(c), 32'd1);
        end
        write_cfg(`OFL_ADDR_ADD_CHAN, 3'd1, 32'd0);
        write_cfg(`OFL_ADDR_ADD_CHAN, 3'd3, 32'd2);
        send_sample(3'd1, delta_t'(rand_bits(18)));
        for (int i = 0; i < N_T3; i++) begin
            send_sample(chan_t'(rand_bits(2)), delta_t'(rand_bits(18)));
        end
        drain();

        // Test 4 injection, requests land while the input is busy
        stage_write(`OFL_ADDR_INJ, 3'd6, 32'd1);
        send_sample(3'd7, delta_t'(rand_bits(18)));
        stage_write(`OFL_ADDR_INJ, 3'd2, 32'd1);
        send_sample(3'd0, delta_t'(rand_bits(18)));
        stage_write(`OFL_ADDR_INJ, 3'd4, 32'd1);
        send_sample(3'd5, delta_t'(rand_bits(18)));
        drain();
        send_sample(3'd2, delta_t'(rand_bits(18)));
        send_sample(3'd4, delta_t'(rand_bits(18)));
        send_sample(3'd6, delta_t'(rand_bits(18)));
        drain();

        // Test 5 clear with an item in flight
        write_cfg(`OFL_ADDR_ADD_CHAN, 3'd5, 32'd4);
        send_sample(3'd4, delta_t'(rand_bits(18)));
        write_cfg(`OFL_ADDR_CLR, 3'd4, 32'd1);
        send_sample(3'd5, delta_t'(rand_bits(18)));
        send_sample(3'd4, delta_t'(rand_bits(18)));
        drain();

        // Test 6 reset mid-stream, partners sent after their readers
        for (int c = `OFL_N_CHAN - 1; c >= 0; c--) begin
            send_sample(chan_t'(c), delta_t'(rand_bits(18)));
        end
        reset_pulse();
        for (int i = 0; i < N_T6; i++) begin
            send_sample(chan_t'(rand_bits(3)), delta_t'(rand_bits(18)));
        end
        drain();

        $display("Errors: mismatch %0d, missing %0d, unexpected %0d",
                 err_mismatch, err_missing, err_unexpected);
        if (err_mismatch + err_missing + err_unexpected == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/ofl_pkg.sv
rtl/ofl_wr_if.sv
rtl/ofl_cfg_regs.sv
rtl/ofl_pipe.sv
rtl/ofl_top.sv
dv/ofl_clk_gen.sv
dv/ofl_sva.sv
dv/ofl_tb.sv

// ==== Bender.yml ====
package:
  name: ofl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ofl_pkg.sv
      - rtl/ofl_wr_if.sv
      - rtl/ofl_cfg_regs.sv
      - rtl/ofl_pipe.sv
      - rtl/ofl_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/ofl_clk_gen.sv
      - dv/ofl_sva.sv
      - dv/ofl_tb.sv
